/* design/poly_pkg.sv */
/* Widths, slot geometry and encodings for the polynomial engine.
   Slot count and degree limit follow the command word layout; change them together. */
package poly_pkg;

   ////////////////////////////// Widths
   localparam int word_w   = 16;                     // Command, data and coefficient words
   localparam int result_w = 32;                     // Horner result, wraps mod 2^32

   ////////////////////////////// Slot geometry
   localparam int num_slots      = 8;                // Polynomial slots
   localparam int slot_w         = 3;                // Slot index, cmd bits 7..5
   localparam int degree_w       = 5;                // Degree argument, cmd bits 4..0
   localparam int index_w        = 4;                // Term index 0..10
   localparam logic [degree_w-1:0] max_degree = 5'd10;  // Anything above is rejected
   localparam int terms_per_slot = 11;               // max_degree + 1
   localparam int store_depth    = 88;               // num_slots * terms_per_slot
   localparam int store_addr_w   = 7;                // Covers store_depth

   typedef logic [store_addr_w-1:0] store_addr_t;    // Flat coefficient address

   ////////////////////////////// Encodings
   // Opcode sits in cmd_word[15:8]
   typedef enum logic [7:0] {
      OP_STP = 8'd0,                                 // Store polynomial
      OP_EVP = 8'd1,                                 // Evaluate at one point
      OP_EVB = 8'd2,                                 // Batch eval, reported as unsupported
      OP_RST = 8'd3                                  // Forget all slots
   } opcode_t;

   typedef enum logic [1:0] {
      ST_OK         = 2'd0,
      ST_BAD_DEGREE = 2'd1,                          // STP degree above max_degree
      ST_EMPTY_SLOT = 2'd2,                          // EVP on slot never stored
      ST_BAD_OPCODE = 2'd3                           // EVB or unknown opcode
   } status_t;

   typedef enum logic [2:0] {
      IDLE,                                          // Accepting commands
      STORE_COEFF,                                   // Collecting STP coefficients
      WAIT_X,                                        // Waiting for EVP point
      EVALUATE,                                      // Horner evaluator busy
      REPORT,                                        // result_valid cycle
      CLEAR                                          // RST wipe cycle
   } seq_state_t;

endpackage

/* design/coeff_store.sv */
/* Coefficient RAM plus per-slot degree table. Reads are registered, one cycle.
   Slot contents are only meaningful while its valid flag is set. */
`timescale 1ns/1ps
module coeff_store
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          wr_en,
   input  logic [poly_pkg::slot_w-1:0]   wr_slot,
   input  logic [poly_pkg::index_w-1:0]  wr_index,
   input  logic [poly_pkg::word_w-1:0]   wr_coeff,
   input  logic                          set_en,
   input  logic [poly_pkg::slot_w-1:0]   set_slot,
   input  logic [poly_pkg::degree_w-1:0] set_degree,
   input  logic                          clear_all,
   input  logic [poly_pkg::slot_w-1:0]   look_slot,
   output logic                          look_valid,
   output logic [poly_pkg::degree_w-1:0] look_degree,
   input  logic                          rd_en,
   input  logic [poly_pkg::slot_w-1:0]   rd_slot,
   input  logic [poly_pkg::index_w-1:0]  rd_index,
   output logic [poly_pkg::word_w-1:0]   rd_coeff
);

   logic [poly_pkg::word_w-1:0]   mem [poly_pkg::store_depth];      // Flat coeff array
   logic [poly_pkg::degree_w-1:0] slot_degree [poly_pkg::num_slots]; // Degree per slot
   logic [poly_pkg::num_slots-1:0] slot_valid;                       // Set by completed STP
   poly_pkg::store_addr_t          wr_addr;
   poly_pkg::store_addr_t          rd_addr;

   // slot * 11 + index
   assign wr_addr = poly_pkg::store_addr_t'(wr_slot * poly_pkg::terms_per_slot + wr_index);
   assign rd_addr = poly_pkg::store_addr_t'(rd_slot * poly_pkg::terms_per_slot + rd_index);

   ////////////////////////////// Coefficient RAM
   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_coeff;                   // Write at the edge
      if (rd_en)
         rd_coeff <= mem[rd_addr];                   // Data next cycle
   end

   ////////////////////////////// Degree table
   always_ff @(posedge clk)
   begin
      if (set_en)
         slot_degree[set_slot] <= set_degree;
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         slot_valid <= '0;                           // All slots empty
      else if (clear_all)
         slot_valid <= '0;                           // RST wins over set_en
      else if (set_en)
         slot_valid[set_slot] <= 1'b1;
   end

   assign look_valid  = slot_valid[look_slot];       // Combinational lookup
   assign look_degree = slot_degree[look_slot];

endmodule

/* design/horner_evaluator.sv */
/* Sequential Horner evaluation, one coefficient per cycle from the top term down.
   eval_done arrives degree+2 cycles after eval_start; no new start while busy. */
`timescale 1ns/1ps
module horner_evaluator
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          eval_start,
   input  logic [poly_pkg::slot_w-1:0]   eval_slot,
   input  logic [poly_pkg::degree_w-1:0] eval_degree,
   input  logic [poly_pkg::word_w-1:0]   eval_x,
   input  logic [poly_pkg::word_w-1:0]   rd_coeff,
   output logic                          rd_en,
   output logic [poly_pkg::slot_w-1:0]   rd_slot,
   output logic [poly_pkg::index_w-1:0]  rd_index,
   output logic                          eval_done,
   output logic [poly_pkg::result_w-1:0] eval_value
);

   logic                          reading;          // Reads still to issue
   logic [poly_pkg::index_w-1:0]  index_q;          // Next term to read
   logic                          acc_pend;         // rd_coeff valid this cycle
   logic                          last_pend;        // ... and it is c_0
   logic [poly_pkg::slot_w-1:0]   slot_q;
   logic [poly_pkg::word_w-1:0]   x_q;
   logic [poly_pkg::result_w-1:0] acc;
   logic [poly_pkg::result_w-1:0] x_ext;
   logic [poly_pkg::result_w-1:0] coeff_ext;

   ////////////////////////////// Read issue
   // First read goes out in the start cycle itself
   assign rd_en    = eval_start | reading;
   assign rd_slot  = eval_start ? eval_slot : slot_q;
   assign rd_index = eval_start ? eval_degree[poly_pkg::index_w-1:0] : index_q;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         reading   <= 1'b0;
         index_q   <= '0;
         acc_pend  <= 1'b0;
         last_pend <= 1'b0;
         eval_done <= 1'b0;
      end
      else
      begin
         acc_pend  <= rd_en;                         // Coeff lands next cycle
         last_pend <= rd_en && (rd_index == '0);
         eval_done <= last_pend;                     // c_0 folded in at this edge
         if (rd_en)
         begin
            reading <= (rd_index != '0);             // Stop after index 0
            index_q <= rd_index - 1'b1;
         end
      end
   end

   ////////////////////////////// Accumulator
   assign x_ext     = {{(poly_pkg::result_w - poly_pkg::word_w){1'b0}}, x_q};
   assign coeff_ext = {{(poly_pkg::result_w - poly_pkg::word_w){1'b0}}, rd_coeff};

   always_ff @(posedge clk)
   begin
      if (eval_start)
      begin
         slot_q <= eval_slot;
         x_q    <= eval_x;
         acc    <= '0;                               // So first fold gives c_N
      end
      else if (acc_pend)
         acc <= acc * x_ext + coeff_ext;             // Truncates to 32 bits
   end

   assign eval_value = acc;                          // Final once eval_done is high

endmodule

/* design/command_sequencer.sv */
/* Command FSM. Takes one command at a time while idle is high; strobes outside the
   expected window are dropped. result and status hold until the next result_valid. */
`timescale 1ns/1ps
module command_sequencer
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          cmd_valid,
   input  logic [poly_pkg::word_w-1:0]   cmd_word,
   input  logic                          data_valid,
   input  logic [poly_pkg::word_w-1:0]   data_word,
   input  logic                          look_valid,
   input  logic [poly_pkg::degree_w-1:0] look_degree,
   input  logic                          eval_done,
   input  logic [poly_pkg::result_w-1:0] eval_value,
   output logic                          idle,
   output logic                          result_valid,
   output logic [poly_pkg::result_w-1:0] result,
   output poly_pkg::status_t             status,
   output logic                          wr_en,
   output logic [poly_pkg::slot_w-1:0]   wr_slot,
   output logic [poly_pkg::index_w-1:0]  wr_index,
   output logic [poly_pkg::word_w-1:0]   wr_coeff,
   output logic                          set_en,
   output logic [poly_pkg::slot_w-1:0]   set_slot,
   output logic [poly_pkg::degree_w-1:0] set_degree,
   output logic                          clear_all,
   output logic [poly_pkg::slot_w-1:0]   look_slot,
   output logic                          eval_start,
   output logic [poly_pkg::slot_w-1:0]   eval_slot,
   output logic [poly_pkg::degree_w-1:0] eval_degree,
   output logic [poly_pkg::word_w-1:0]   eval_x
);

   poly_pkg::seq_state_t          state;
   poly_pkg::opcode_t             cmd_op;
   logic [poly_pkg::slot_w-1:0]   cmd_slot;
   logic [poly_pkg::degree_w-1:0] cmd_degree;
   logic [poly_pkg::slot_w-1:0]   slot_q;           // Target slot of current cmd
   logic [poly_pkg::degree_w-1:0] degree_q;         // STP arg or stored EVP degree
   logic [poly_pkg::index_w-1:0]  idx_q;            // Next coeff index, counts down

   ////////////////////////////// Command word fields
   assign cmd_op     = poly_pkg::opcode_t'(cmd_word[15:8]);
   assign cmd_slot   = cmd_word[7:5];
   assign cmd_degree = cmd_word[4:0];

   assign idle      = (state == poly_pkg::IDLE);
   assign look_slot = cmd_slot;                      // Looked up in the accept cycle

   ////////////////////////////// Store side
   assign wr_en      = (state == poly_pkg::STORE_COEFF) && data_valid;
   assign wr_slot    = slot_q;
   assign wr_index   = idx_q;
   assign wr_coeff   = data_word;
   assign set_en     = wr_en && (idx_q == '0);       // With the last coeff
   assign set_slot   = slot_q;
   assign set_degree = degree_q;
   assign clear_all  = (state == poly_pkg::CLEAR);

   ////////////////////////////// Evaluator side
   assign eval_start  = (state == poly_pkg::WAIT_X) && data_valid;
   assign eval_slot   = slot_q;
   assign eval_degree = degree_q;
   assign eval_x      = data_word;                   // x passes straight through

   always_ff @(posedge clk)
   begin
      if (idle && cmd_valid)
      begin
         slot_q <= cmd_slot;
         // EVP takes the stored degree, STP its own argument
         degree_q <= (cmd_op == poly_pkg::OP_EVP) ? look_degree : cmd_degree;
      end
   end

   ////////////////////////////// Main FSM
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state        <= poly_pkg::IDLE;
         idx_q        <= '0;
         result_valid <= 1'b0;
         result       <= '0;
         status       <= poly_pkg::ST_OK;
      end
      else
      begin
         result_valid <= 1'b0;                       // Pulse by default
         case (state)
            poly_pkg::IDLE:
            begin
               if (cmd_valid)
               begin
                  case (cmd_op)
                     poly_pkg::OP_STP:
                     begin
                        if (cmd_degree > poly_pkg::max_degree)
                        begin
                           result_valid <= 1'b1;     // Reject, no data taken
                           result       <= '0;
                           status       <= poly_pkg::ST_BAD_DEGREE;
                           state        <= poly_pkg::REPORT;
                        end
                        else
                        begin
                           idx_q <= cmd_degree[poly_pkg::index_w-1:0];  // Highest first
                           state <= poly_pkg::STORE_COEFF;
                        end
                     end
                     poly_pkg::OP_EVP:
                     begin
                        if (!look_valid)
                        begin
                           result_valid <= 1'b1;     // x is never awaited
                           result       <= '0;
                           status       <= poly_pkg::ST_EMPTY_SLOT;
                           state        <= poly_pkg::REPORT;
                        end
                        else
                           state <= poly_pkg::WAIT_X;
                     end
                     poly_pkg::OP_RST:
                        state <= poly_pkg::CLEAR;
                     default:
                     begin
                        result_valid <= 1'b1;        // EVB lands here too
                        result       <= '0;
                        status       <= poly_pkg::ST_BAD_OPCODE;
                        state        <= poly_pkg::REPORT;
                     end
                  endcase
               end
            end
            poly_pkg::STORE_COEFF:
            begin
               if (data_valid)
               begin
                  idx_q <= idx_q - 1'b1;
                  if (idx_q == '0)
                  begin
                     result_valid <= 1'b1;           // Next cycle after last coeff
                     result       <= '0;
                     status       <= poly_pkg::ST_OK;
                     state        <= poly_pkg::REPORT;
                  end
               end
            end
            poly_pkg::WAIT_X:
               if (data_valid)
                  state <= poly_pkg::EVALUATE;       // eval_start fired this cycle
            poly_pkg::EVALUATE:
            begin
               if (eval_done)
               begin
                  result_valid <= 1'b1;
                  result       <= eval_value;
                  status       <= poly_pkg::ST_OK;
                  state        <= poly_pkg::REPORT;
               end
            end
            poly_pkg::REPORT:
               state <= poly_pkg::IDLE;              // idle back after the pulse
            poly_pkg::CLEAR:
               state <= poly_pkg::IDLE;              // No result for RST
            default:
               state <= poly_pkg::IDLE;
         endcase
      end
   end

endmodule

/* design/poly_engine.sv */
/* Polynomial engine top, with no back-pressure. Drive cmd_valid only while idle is high
   and capture result and status on the result_valid pulse. */
`timescale 1ns/1ps
module poly_engine
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          cmd_valid,
   input  logic [poly_pkg::word_w-1:0]   cmd_word,
   input  logic                          data_valid,
   input  logic [poly_pkg::word_w-1:0]   data_word,
   output logic                          idle,
   output logic                          result_valid,
   output logic [poly_pkg::result_w-1:0] result,
   output poly_pkg::status_t             status
);

   ////////////////////////////// Sequencer to store
   logic                          wr_en;
   logic [poly_pkg::slot_w-1:0]   wr_slot;
   logic [poly_pkg::index_w-1:0]  wr_index;
   logic [poly_pkg::word_w-1:0]   wr_coeff;
   logic                          set_en;
   logic [poly_pkg::slot_w-1:0]   set_slot;
   logic [poly_pkg::degree_w-1:0] set_degree;
   logic                          clear_all;
   logic [poly_pkg::slot_w-1:0]   look_slot;
   logic                          look_valid;
   logic [poly_pkg::degree_w-1:0] look_degree;

   ////////////////////////////// Evaluator links
   logic                          rd_en;
   logic [poly_pkg::slot_w-1:0]   rd_slot;
   logic [poly_pkg::index_w-1:0]  rd_index;
   logic [poly_pkg::word_w-1:0]   rd_coeff;
   logic                          eval_start;
   logic [poly_pkg::slot_w-1:0]   eval_slot;
   logic [poly_pkg::degree_w-1:0] eval_degree;
   logic [poly_pkg::word_w-1:0]   eval_x;
   logic                          eval_done;
   logic [poly_pkg::result_w-1:0] eval_value;

   command_sequencer command_sequencer_i (
      .clk(clk), .rst(rst),
      .cmd_valid(cmd_valid), .cmd_word(cmd_word),
      .data_valid(data_valid), .data_word(data_word),
      .look_valid(look_valid), .look_degree(look_degree),
      .eval_done(eval_done), .eval_value(eval_value),
      .idle(idle), .result_valid(result_valid), .result(result), .status(status),
      .wr_en(wr_en), .wr_slot(wr_slot), .wr_index(wr_index), .wr_coeff(wr_coeff),
      .set_en(set_en), .set_slot(set_slot), .set_degree(set_degree),
      .clear_all(clear_all), .look_slot(look_slot),
      .eval_start(eval_start), .eval_slot(eval_slot),
      .eval_degree(eval_degree), .eval_x(eval_x)
   );

   coeff_store coeff_store_i (
      .clk(clk), .rst(rst),
      .wr_en(wr_en), .wr_slot(wr_slot), .wr_index(wr_index), .wr_coeff(wr_coeff),
      .set_en(set_en), .set_slot(set_slot), .set_degree(set_degree),
      .clear_all(clear_all),
      .look_slot(look_slot), .look_valid(look_valid), .look_degree(look_degree),
      .rd_en(rd_en), .rd_slot(rd_slot), .rd_index(rd_index), .rd_coeff(rd_coeff)
   );

   horner_evaluator horner_evaluator_i (
      .clk(clk), .rst(rst),
      .eval_start(eval_start), .eval_slot(eval_slot),
      .eval_degree(eval_degree), .eval_x(eval_x), .rd_coeff(rd_coeff),
      .rd_en(rd_en), .rd_slot(rd_slot), .rd_index(rd_index),
      .eval_done(eval_done), .eval_value(eval_value)
   );

endmodule

/* bench/poly_model.svh */
/* Slot model and compare tasks, meant to be included inside the testbench module.
   Expected values use the power sum of c_i * x^i, wrapped to 32 bits. */
`ifndef POLY_MODEL_SVH
`define POLY_MODEL_SVH

////////////////////////////// Slot model
logic [poly_pkg::word_w-1:0]   model_coeff [poly_pkg::num_slots][poly_pkg::terms_per_slot];
logic [poly_pkg::word_w-1:0]   stage_coeff [poly_pkg::terms_per_slot];  // Words of open STP
logic [poly_pkg::degree_w-1:0] model_degree [poly_pkg::num_slots];
logic                          model_valid [poly_pkg::num_slots];       // Slot stored

task automatic model_clear();
   int s;
   for (s = 0; s < poly_pkg::num_slots; s++)
      model_valid[s] = 1'b0;                         // RST or power-up
endtask

task automatic model_commit(input logic [poly_pkg::slot_w-1:0] slot,
                            input logic [poly_pkg::degree_w-1:0] degree);
   int i;
   for (i = 0; i < poly_pkg::terms_per_slot; i++)
      model_coeff[slot][i] = stage_coeff[i];         // Unused terms never read
   model_degree[slot] = degree;
   model_valid[slot]  = 1'b1;
endtask

// Sum of c_i * x^i, independent of the Horner order in the DUT
function automatic logic [poly_pkg::result_w-1:0] model_value(
   input logic [poly_pkg::slot_w-1:0] slot, input logic [poly_pkg::word_w-1:0] x);
   logic [poly_pkg::result_w-1:0] sum;
   logic [poly_pkg::result_w-1:0] power;
   int i;
   sum   = '0;
   power = 32'd1;                                    // x^0
   for (i = 0; i <= int'(model_degree[slot]); i++)
   begin
      sum   = sum + {16'd0, model_coeff[slot][i]} * power;
      power = power * {16'd0, x};                    // Wraps mod 2^32
   end
   return sum;
endfunction

////////////////////////////// Compare tasks
task automatic check_result(input logic [poly_pkg::result_w-1:0] expected,
                            input logic [poly_pkg::result_w-1:0] actual);
   if (actual !== expected)
   begin
      $display("mismatch result: expected %h actual %h", expected, actual);
      $display("TEST FAILED");
      $fatal(1, "result compare");
   end
endtask

task automatic check_status(input poly_pkg::status_t expected,
                            input poly_pkg::status_t actual);
   if (actual !== expected)
   begin
      $display("mismatch status: expected %h actual %h", expected, actual);
      $display("TEST FAILED");
      $fatal(1, "status compare");
   end
endtask

`endif

/* bench/tb_poly_engine.sv */
/* Testbench for poly_engine with directed corner cases, then a seeded random command
   stream. Stops at the first error; a cycle counter bounds the whole run. */
`timescale 1ns/1ps
module tb_poly_engine;

   localparam int num_random   = 300;                // Random commands
   localparam int num_directed = 40;                 // Directed commands, rounded up
   localparam int cmd_cycles   = 30;                 // Worst case per command
   localparam int cycle_limit  = (num_random + num_directed) * cmd_cycles + 100;

   logic                          clk;
   logic                          rst;
   logic                          cmd_valid;
   logic [poly_pkg::word_w-1:0]   cmd_word;
   logic                          data_valid;
   logic [poly_pkg::word_w-1:0]   data_word;
   logic                          idle;
   logic                          result_valid;
   logic [poly_pkg::result_w-1:0] result;
   poly_pkg::status_t             status;
   integer                        seed;
   int                            cycle_count = 0;
   int                            n;
   int                            pick;

   `include "poly_model.svh"

   poly_engine poly_engine_i (
      .clk(clk), .rst(rst),
      .cmd_valid(cmd_valid), .cmd_word(cmd_word),
      .data_valid(data_valid), .data_word(data_word),
      .idle(idle), .result_valid(result_valid), .result(result), .status(status)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;                        // 100 ns period
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $fatal(1, "cycle limit reached");
      end
   end

   ////////////////////////////// Helpers
   task automatic report_failure(input string what);
      $display("error: %s", what);
      $display("TEST FAILED");
      $fatal(1, "check failed");
   endtask

   function automatic int pick_below(input int limit);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % limit);
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;                                            // Drive just after the edge
   endtask

   task automatic send_cmd(input logic [7:0] op, input logic [2:0] slot,
                           input logic [4:0] degree);
      while (!idle)
         next_cycle();
      cmd_valid = 1'b1;
      cmd_word  = {op, slot, degree};
      next_cycle();
      cmd_valid = 1'b0;
      if (idle)
         report_failure("idle still high the cycle after an accepted command");
   endtask

   task automatic send_data(input logic [15:0] word);
      data_valid = 1'b1;
      data_word  = word;
      next_cycle();
      data_valid = 1'b0;
   endtask

   task automatic expect_pulse_now(input string what);
      if (result_valid !== 1'b1)
         report_failure({"result_valid missing one cycle after ", what});
   endtask

   // Strobes while busy must not disturb the running command
   task automatic inject_busy_strobe(input bit with_data);
      if (idle)
         report_failure("idle high while a command is in flight");
      cmd_valid = 1'b1;
      cmd_word  = {8'(poly_pkg::OP_RST), 3'(pick_below(8)), 5'(pick_below(32))};
      if (with_data)
      begin
         data_valid = 1'b1;
         data_word  = 16'(pick_below(65536));
      end
      next_cycle();
      cmd_valid  = 1'b0;
      data_valid = 1'b0;
   endtask

   task automatic inject_idle_data();
      while (!idle)
         next_cycle();
      send_data(16'(pick_below(65536)));             // Nothing expects data now
      if (!idle || result_valid)
         report_failure("data strobe while idle was not ignored");
   endtask

   ////////////////////////////// Command tasks
   task automatic do_stp(input logic [2:0] slot, input logic [4:0] degree, input bit noisy);
      int i;
      send_cmd(8'(poly_pkg::OP_STP), slot, degree);
      if (degree > poly_pkg::max_degree)
      begin
         expect_pulse_now("STP with bad degree");
         check_status(poly_pkg::ST_BAD_DEGREE, status);  // Model slot untouched
      end
      else
      begin
         for (i = int'(degree); i >= 0; i--)         // Highest degree first
         begin
            stage_coeff[i] = 16'(pick_below(65536));
            if (noisy && pick_below(5) == 0)
               inject_busy_strobe(1'b0);
            send_data(stage_coeff[i]);
         end
         expect_pulse_now("last STP coefficient");
         check_result('0, result);
         check_status(poly_pkg::ST_OK, status);
         model_commit(slot, degree);
      end
   endtask

   task automatic do_evp(input logic [2:0] slot, input logic [15:0] x, input bit noisy);
      send_cmd(8'(poly_pkg::OP_EVP), slot, 5'(pick_below(32)));  // Degree bits unused
      if (!model_valid[slot])
      begin
         expect_pulse_now("EVP on an empty slot");
         check_status(poly_pkg::ST_EMPTY_SLOT, status);
      end
      else
      begin
         send_data(x);
         while (!result_valid)                       // Latency follows the degree
         begin
            if (noisy && pick_below(4) == 0)
               inject_busy_strobe(1'b1);
            else
               next_cycle();
         end
         check_result(model_value(slot, x), result);
         check_status(poly_pkg::ST_OK, status);
      end
   endtask

   task automatic do_bad_op(input logic [7:0] op);
      send_cmd(op, 3'(pick_below(8)), 5'(pick_below(32)));
      expect_pulse_now("unsupported opcode");
      check_status(poly_pkg::ST_BAD_OPCODE, status);
   endtask

   task automatic do_rst();
      send_cmd(8'(poly_pkg::OP_RST), 3'(pick_below(8)), 5'(pick_below(32)));
      while (!idle)
      begin
         if (result_valid)
            report_failure("RST produced a result_valid pulse");
         next_cycle();
      end
      if (result_valid)
         report_failure("RST produced a result_valid pulse");
      model_clear();
   endtask

   function automatic logic [15:0] pick_x();
      pick = pick_below(10);
      if (pick == 0)
         return 16'h0000;
      else if (pick == 1)
         return 16'hffff;
      return 16'(pick_below(65536));
   endfunction

   ////////////////////////////// Stimulus
   initial
   begin
      seed       = 32'h9009_2c6f;
      rst        = 1'b0;
      cmd_valid  = 1'b0;
      cmd_word   = '0;
      data_valid = 1'b0;
      data_word  = '0;
      model_clear();
      repeat (2) @(posedge clk);                     // Reset for 2 cycles
      #1;
      rst = 1'b1;
      if (!idle || result_valid)
         report_failure("idle low or result_valid high after reset");
      check_result('0, result);
      check_status(poly_pkg::ST_OK, status);

      for (n = 0; n < poly_pkg::num_slots; n++)      // All empty at start
         do_evp(3'(n), 16'(pick_below(65536)), 1'b0);
      do_stp(3'd0, 5'd10, 1'b0);                     // Largest degree
      do_stp(3'd1, 5'd0, 1'b0);                      // Constant only
      do_evp(3'd0, 16'h0000, 1'b0);
      do_evp(3'd0, 16'hffff, 1'b0);
      do_evp(3'd0, 16'(pick_below(65536)), 1'b0);
      do_evp(3'd1, 16'h0000, 1'b0);
      do_evp(3'd1, 16'hffff, 1'b0);
      do_stp(3'd0, 5'd20, 1'b0);                     // Rejected, old poly stays
      do_evp(3'd0, 16'h1234, 1'b0);
      do_stp(3'd5, 5'd31, 1'b0);
      do_evp(3'd5, 16'h0042, 1'b0);                  // Still empty
      do_bad_op(8'd2);                               // EVB
      do_bad_op(8'd4);
      do_bad_op(8'd255);
      do_rst();
      for (n = 0; n < poly_pkg::num_slots; n++)
         do_evp(3'(n), 16'(pick_below(65536)), 1'b0);

      for (n = 0; n < num_random; n++)
      begin
         if (pick_below(10) == 0)
            inject_idle_data();
         pick = pick_below(100);
         if (pick < 40)
            do_stp(3'(pick_below(8)), 5'(pick_below(11)), 1'b1);
         else if (pick < 80)
            do_evp(3'(pick_below(8)), pick_x(), 1'b1);
         else if (pick < 88)
            do_stp(3'(pick_below(8)), 5'(11 + pick_below(21)), 1'b0);
         else if (pick < 96)
            do_bad_op(pick_below(2) == 0 ? 8'd2 : 8'(4 + pick_below(252)));
         else
            do_rst();
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule

/* sources.f */
+incdir+bench
design/poly_pkg.sv
design/coeff_store.sv
design/horner_evaluator.sv
design/command_sequencer.sv
design/poly_engine.sv
bench/tb_poly_engine.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and decide on the printed verdict.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_poly_engine -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_poly_engine)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "TEST PASSED"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
